//--- src.f
+incdir+.
cpu_pkg.sv
alu.sv
arm_core.sv
axil_host_port.sv
mem_arbiter.sv
unified_mem.sv
cpu_top.sv
tb_cpu.sv

//--- Makefile
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall -f src.f --top-module cpu_top

sim:
	verilator --binary -f src.f --top-module tb_cpu -o tb_cpu
	./obj_dir/tb_cpu 2>&1 | tee $(LOG)
	grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tb_cpu.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module tb_cpu;

  // host reads this word during runs, no program touches it
  localparam int sentinel_word = 60;

  logic                clk;
  logic                nreset;
  logic                run;
  logic                halted;
  cpu_pkg::axil_req_t  host_req;
  cpu_pkg::axil_rsp_t  host_rsp;

  logic [`XLEN-1:0] prog_img [0:`MEM_WORDS-1];
  logic [`XLEN-1:0] exp_img [0:`MEM_WORDS-1];
  int               pc_w;
  // budget for reset and the host access test
  time              deadline = 64'(40 * 20 + 200) * 64'd40;

  // flag test cases, kind 0 cmp, 1 adds, 2 subs
  int               flag_kind [0:5];
  logic [`XLEN-1:0] flag_a [0:5];
  logic [`XLEN-1:0] flag_b [0:5];

  cpu_top u_cpu_top (
    .clk      (clk),
    .nreset   (nreset),
    .run      (run),
    .halted   (halted),
    .host_req (host_req),
    .host_rsp (host_rsp)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  task automatic check_word(input string name, input logic [`XLEN-1:0] expected,
                            input logic [`XLEN-1:0] actual);
    if (actual !== expected) begin
      $display("error %s: expected %08h actual %08h", name, expected, actual);
      $display("*** FAILED ***");
      $fatal(1);
    end
  endtask

  task automatic check_resp(input string name, input cpu_pkg::axil_resp_e expected,
                            input cpu_pkg::axil_resp_e actual);
    if (actual !== expected) begin
      $display("error %s: expected %s actual %0d", name, expected.name(), actual);
      $display("*** FAILED ***");
      $fatal(1);
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("error %s: expected %b actual %b", name, expected, actual);
      $display("*** FAILED ***");
      $fatal(1);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    nreset   <= 1'b0;
    run      <= 1'b0;
    host_req <= '0;
    repeat (4) @(posedge clk);
    nreset <= 1'b1;
    @(posedge clk);
  endtask

  task automatic axil_write(input logic [31:0] addr, input logic [`XLEN-1:0] data,
                            output cpu_pkg::axil_resp_e resp);
    @(posedge clk);
    host_req.awvalid <= 1'b1;
    host_req.awaddr  <= addr;
    host_req.wvalid  <= 1'b1;
    host_req.wdata   <= data;
    host_req.bready  <= 1'b1;
    do @(posedge clk); while (!host_rsp.awready);
    host_req.awvalid <= 1'b0;
    host_req.wvalid  <= 1'b0;
    do @(posedge clk); while (!host_rsp.bvalid);
    resp = host_rsp.bresp;
    host_req.bready <= 1'b0;
  endtask

  // rready stays low for rready_delay cycles after rvalid
  task automatic axil_read(input logic [31:0] addr, input int rready_delay,
                           output logic [`XLEN-1:0] data, output cpu_pkg::axil_resp_e resp);
    @(posedge clk);
    host_req.arvalid <= 1'b1;
    host_req.araddr  <= addr;
    host_req.rready  <= 1'b0;
    do @(posedge clk); while (!host_rsp.arready);
    host_req.arvalid <= 1'b0;
    do @(posedge clk); while (!host_rsp.rvalid);
    repeat (rready_delay) @(posedge clk);
    host_req.rready <= 1'b1;
    @(posedge clk);
    data = host_rsp.rdata;
    resp = host_rsp.rresp;
    host_req.rready <= 1'b0;
  endtask

  function automatic logic cond_holds(input cpu_pkg::cond_e c, input cpu_pkg::flags_t f);
    case (c)
      cpu_pkg::cond_eq: return f.z;
      cpu_pkg::cond_ne: return !f.z;
      cpu_pkg::cond_cs: return f.c;
      cpu_pkg::cond_cc: return !f.c;
      cpu_pkg::cond_mi: return f.n;
      cpu_pkg::cond_pl: return !f.n;
      cpu_pkg::cond_vs: return f.v;
      cpu_pkg::cond_vc: return !f.v;
      cpu_pkg::cond_hi: return f.c && !f.z;
      cpu_pkg::cond_ls: return !f.c || f.z;
      cpu_pkg::cond_ge: return f.n == f.v;
      cpu_pkg::cond_lt: return f.n != f.v;
      cpu_pkg::cond_gt: return !f.z && (f.n == f.v);
      cpu_pkg::cond_le: return f.z || (f.n != f.v);
      default: return 1'b1;
    endcase
  endfunction

  function automatic void alu_ref(input cpu_pkg::opcode_e op, input logic [31:0] a,
                                  input logic [31:0] b, input cpu_pkg::flags_t fin,
                                  output logic [31:0] res, output cpu_pkg::flags_t fout,
                                  output logic wr);
    logic [32:0] wide;
    logic [31:0] x;
    logic [31:0] y;
    logic        borrow_in;
    fout      = fin;
    x         = a;
    y         = b;
    borrow_in = 1'b0;
    case (op)
      cpu_pkg::op_and, cpu_pkg::op_tst: res = a & b;
      cpu_pkg::op_eor, cpu_pkg::op_teq: res = a ^ b;
      cpu_pkg::op_orr: res = a | b;
      cpu_pkg::op_mov: res = b;
      cpu_pkg::op_bic: res = a & ~b;
      cpu_pkg::op_mvn: res = ~b;
      cpu_pkg::op_add, cpu_pkg::op_cmn, cpu_pkg::op_adc: begin
        wide = {1'b0, a} + {1'b0, b} + ((op == cpu_pkg::op_adc) ? {32'b0, fin.c} : 33'd0);
        res    = wide[31:0];
        fout.c = wide[32];
        fout.v = (a[31] == b[31]) && (res[31] != a[31]);
      end
      default: begin
        // x - y - borrow, reverse forms swap the operands
        if (op inside {cpu_pkg::op_rsb, cpu_pkg::op_rsc}) begin
          x = b;
          y = a;
        end
        if (op inside {cpu_pkg::op_sbc, cpu_pkg::op_rsc}) begin
          borrow_in = !fin.c;
        end
        res    = x - y - {31'b0, borrow_in};
        fout.c = ({1'b0, x} >= ({1'b0, y} + {32'b0, borrow_in}));
        fout.v = (x[31] != y[31]) && (res[31] != x[31]);
      end
    endcase
    fout.n = res[31];
    fout.z = (res == 32'd0);
    wr = !(op inside {cpu_pkg::op_tst, cpu_pkg::op_teq, cpu_pkg::op_cmp, cpu_pkg::op_cmn});
  endfunction

  // runs prog_img into exp_img, returns the executed instruction count
  function automatic int iss_run();
    logic [31:0]     r [0:15];
    cpu_pkg::flags_t f;
    cpu_pkg::flags_t fo;
    logic [31:0]     pc;
    logic [31:0]     nxt;
    logic [31:0]     ir;
    logic [31:0]     rnv;
    logic [31:0]     rdv;
    logic [31:0]     rmv;
    logic [31:0]     res;
    logic [31:0]     addr;
    logic [31:0]     tgt;
    logic            wr;
    int              n;
    for (int i = 0; i < `MEM_WORDS; i++) begin
      exp_img[i] = prog_img[i];
    end
    for (int i = 0; i < 16; i++) begin
      r[i] = '0;
    end
    f  = '0;
    pc = '0;
    n  = 0;
    while (n < 4000) begin
      ir  = exp_img[pc[`MEM_AW+1:2]];
      n   = n + 1;
      nxt = pc + 4;
      rnv = (ir[19:16] == 4'd15) ? pc + `PC_AHEAD : r[ir[19:16]];
      rdv = (ir[15:12] == 4'd15) ? pc + `PC_AHEAD : r[ir[15:12]];
      rmv = (ir[3:0] == 4'd15) ? pc + `PC_AHEAD : r[ir[3:0]];
      if (cond_holds(cpu_pkg::cond_e'(ir[31:28]), f)) begin
        case (cpu_pkg::inst_class_e'(ir[27:26]))
          cpu_pkg::class_dp: begin
            alu_ref(cpu_pkg::opcode_e'(ir[24:21]), rnv,
                    ir[25] ? {24'b0, ir[7:0]} : rmv, f, res, fo, wr);
            if (wr && ir[15:12] != 4'd15) begin
              r[ir[15:12]] = res;
            end
            if (ir[20]) begin
              f = fo;
            end
          end
          cpu_pkg::class_ldst: begin
            addr = rnv + {20'b0, ir[11:0]};
            if (!ir[20]) begin
              exp_img[addr[`MEM_AW+1:2]] = rdv;
            end else if (ir[15:12] != 4'd15) begin
              r[ir[15:12]] = exp_img[addr[`MEM_AW+1:2]];
            end
          end
          cpu_pkg::class_branch: begin
            tgt = pc + `PC_AHEAD + {{6{ir[23]}}, ir[23:0], 2'b00};
            if (ir[24]) begin
              r[`REG_LR] = pc + 4;
            end
            if (tgt == pc) begin
              return n;
            end
            nxt = tgt;
          end
          default: ;
        endcase
      end
      pc = nxt;
    end
    return n;
  endfunction

  function automatic logic [31:0] enc_dp(input cpu_pkg::cond_e c, input cpu_pkg::opcode_e op,
                                         input int s, input int rd, input int rn,
                                         input int imm, input int op2);
    return {c, 2'b00, imm[0], op, s[0], rn[3:0], rd[3:0],
            imm[0] ? {4'b0, op2[7:0]} : {8'b0, op2[3:0]}};
  endfunction

  function automatic logic [31:0] enc_ldst(input cpu_pkg::cond_e c, input int load,
                                           input int rd, input int rn, input int off);
    return {c, 2'b01, 5'b0, load[0], rn[3:0], rd[3:0], off[11:0]};
  endfunction

  function automatic logic [31:0] enc_branch(input cpu_pkg::cond_e c, input int link,
                                             input int from_word, input int to_word);
    int off;
    off = to_word - from_word - 2;
    return {c, 2'b10, 1'b0, link[0], off[23:0]};
  endfunction

  function automatic void emit(input logic [31:0] inst);
    prog_img[pc_w] = inst;
    pc_w = pc_w + 1;
  endfunction

  function automatic void clear_image();
    for (int i = 0; i < `MEM_WORDS; i++) begin
      prog_img[i] = 32'hc0de_0000 | 32'(i * 257);
    end
    prog_img[sentinel_word] = $urandom;
    pc_w = 0;
  endfunction

  // operands in words 62 and 63, results from word 40
  function automatic void build_dp_program(input int first_op);
    cpu_pkg::opcode_e op;
    clear_image();
    prog_img[62] = $urandom;
    prog_img[63] = $urandom;
    emit(enc_ldst(cpu_pkg::cond_al, 1, 1, 0, 248));
    emit(enc_ldst(cpu_pkg::cond_al, 1, 2, 0, 252));
    for (int k = 0; k < 8; k++) begin
      op = cpu_pkg::opcode_e'(4'(first_op + k));
      emit(enc_dp(cpu_pkg::cond_al, op, 1, 3, 1, 0, 2));
      emit(enc_ldst(cpu_pkg::cond_al, 0, 3, 0, 160 + 8 * k));
      emit(enc_dp(cpu_pkg::cond_al, op, 1, 3, 1, 1, int'($urandom_range(0, 255))));
      emit(enc_ldst(cpu_pkg::cond_al, 0, 3, 0, 164 + 8 * k));
    end
    emit(enc_branch(cpu_pkg::cond_al, 0, pc_w, pc_w));
  endfunction

  // two cases, operands from word 56 and condition masks from word 48
  function automatic void build_flags_program(input int first);
    cpu_pkg::opcode_e op;
    int               mreg;
    clear_image();
    for (int c = 0; c < 2; c++) begin
      prog_img[56 + 2 * c] = flag_a[first + c];
      prog_img[57 + 2 * c] = flag_b[first + c];
      emit(enc_ldst(cpu_pkg::cond_al, 1, 1, 0, 4 * (56 + 2 * c)));
      emit(enc_ldst(cpu_pkg::cond_al, 1, 2, 0, 4 * (57 + 2 * c)));
      case (flag_kind[first + c])
        0: op = cpu_pkg::op_cmp;
        1: op = cpu_pkg::op_add;
        default: op = cpu_pkg::op_sub;
      endcase
      emit(enc_dp(cpu_pkg::cond_al, op, 1, 3, 1, 0, 2));
      emit(enc_dp(cpu_pkg::cond_al, cpu_pkg::op_mov, 0, 5, 0, 1, 0));
      emit(enc_dp(cpu_pkg::cond_al, cpu_pkg::op_mov, 0, 6, 0, 1, 0));
      // one mask bit per condition, r5 low eight and r6 the rest
      for (int i = 0; i < 15; i++) begin
        mreg = (i < 8) ? 5 : 6;
        emit(enc_dp(cpu_pkg::cond_e'(4'(i)), cpu_pkg::op_orr, 0, mreg, mreg, 1, 1 << (i % 8)));
      end
      emit(enc_ldst(cpu_pkg::cond_al, 0, 5, 0, 4 * (48 + 2 * c)));
      emit(enc_ldst(cpu_pkg::cond_al, 0, 6, 0, 4 * (49 + 2 * c)));
    end
    emit(enc_branch(cpu_pkg::cond_al, 0, pc_w, pc_w));
  endfunction

  function automatic void build_branch_program();
    clear_image();
    emit(enc_dp(cpu_pkg::cond_al, cpu_pkg::op_mov, 0, 1, 0, 1, int'($urandom_range(3, 10))));
    emit(enc_dp(cpu_pkg::cond_al, cpu_pkg::op_mov, 0, 2, 0, 1, 0));
    // loop body at word 2
    emit(enc_dp(cpu_pkg::cond_al, cpu_pkg::op_add, 0, 2, 2, 1, 3));
    emit(enc_dp(cpu_pkg::cond_al, cpu_pkg::op_sub, 1, 1, 1, 1, 1));
    emit(enc_branch(cpu_pkg::cond_ne, 0, 4, 2));
    emit(enc_ldst(cpu_pkg::cond_al, 0, 2, 0, 200));
    emit(enc_branch(cpu_pkg::cond_al, 1, 6, 10));
    emit(enc_dp(cpu_pkg::cond_al, cpu_pkg::op_mov, 0, 7, 0, 1, 8'h5a));
    emit(enc_ldst(cpu_pkg::cond_al, 0, 7, 0, 208));
    emit(enc_branch(cpu_pkg::cond_al, 0, 9, 9));
    // subroutine at word 10, the write to r15 has no effect
    emit(enc_ldst(cpu_pkg::cond_al, 0, `REG_LR, 0, 204));
    emit(enc_dp(cpu_pkg::cond_al, cpu_pkg::op_mov, 0, `REG_PC, 0, 1, 0));
    emit(enc_branch(cpu_pkg::cond_al, 0, 12, 7));
  endfunction

  task automatic host_access_test();
    logic [`XLEN-1:0]    model [0:`MEM_WORDS-1];
    logic [`XLEN-1:0]    rdata;
    logic [31:0]         oor;
    cpu_pkg::axil_resp_e resp;
    int                  addrs [$];
    int                  a;
    check_bit("reset halted", 1'b0, halted);
    check_bit("reset awready", 1'b0, host_rsp.awready);
    check_bit("reset wready", 1'b0, host_rsp.wready);
    check_bit("reset arready", 1'b0, host_rsp.arready);
    check_bit("reset bvalid", 1'b0, host_rsp.bvalid);
    check_bit("reset rvalid", 1'b0, host_rsp.rvalid);
    for (int k = 0; k < 16; k++) begin
      a = int'($urandom_range(0, `MEM_WORDS - 1));
      model[a] = $urandom;
      addrs.push_back(a);
      axil_write(32'(4 * a), model[a], resp);
      check_resp("host write", cpu_pkg::resp_okay, resp);
    end
    foreach (addrs[k]) begin
      axil_read(32'(4 * addrs[k]), 0, rdata, resp);
      check_resp("host read", cpu_pkg::resp_okay, resp);
      check_word($sformatf("host read word %0d", addrs[k]), model[addrs[k]], rdata);
    end
    oor = 32'(4 * `MEM_WORDS) + 32'($urandom_range(0, 4000));
    axil_write(oor, $urandom, resp);
    check_resp("out of range write", cpu_pkg::resp_slverr, resp);
    axil_read(oor, 0, rdata, resp);
    check_resp("out of range read", cpu_pkg::resp_slverr, resp);
    check_word("out of range read data", '0, rdata);
  endtask

  task automatic run_program(input string name);
    logic [`XLEN-1:0]    rdata;
    cpu_pkg::axil_resp_e resp;
    int                  icount;
    icount = iss_run();
    apply_reset();
    deadline = $time + 64'(icount * 10 + 2 * `MEM_WORDS * 20 + 4 * 30 + 50) * 64'd40;
    for (int a = 0; a < `MEM_WORDS; a++) begin
      axil_write(32'(4 * a), prog_img[a], resp);
      check_resp($sformatf("%s load %0d", name, a), cpu_pkg::resp_okay, resp);
    end
    run <= 1'b1;
    // host traffic against the running core
    for (int k = 0; k < 4; k++) begin
      axil_read(32'(4 * sentinel_word), int'($urandom_range(0, 6)), rdata, resp);
      check_resp($sformatf("%s contention read", name), cpu_pkg::resp_okay, resp);
      check_word($sformatf("%s contention read", name), prog_img[sentinel_word], rdata);
    end
    while (!halted) @(posedge clk);
    for (int a = 0; a < `MEM_WORDS; a++) begin
      axil_read(32'(4 * a), 0, rdata, resp);
      check_resp($sformatf("%s word %0d", name, a), cpu_pkg::resp_okay, resp);
      check_word($sformatf("%s word %0d", name, a), exp_img[a], rdata);
    end
  endtask

  initial begin
    while ($time <= deadline) @(posedge clk);
    $display("timeout: the DUT did not finish within the time budget");
    $display("*** FAILED ***");
    $fatal(1, "watchdog expired");
  end

  initial begin
    void'($urandom(32'h90a43c32));
    nreset   <= 1'b0;
    run      <= 1'b0;
    host_req <= '0;
    apply_reset();
    host_access_test();

    build_dp_program(0);
    run_program("dp ops 0 to 7");
    build_dp_program(8);
    run_program("dp ops 8 to 15");

    flag_kind[0] = 0;
    flag_a[0]    = $urandom;
    flag_b[0]    = $urandom;
    flag_kind[1] = 0;
    flag_a[1]    = $urandom;
    flag_b[1]    = flag_a[1];
    flag_kind[2] = 1;
    flag_a[2]    = 32'h7fff_ffff;
    flag_b[2]    = 32'h1;
    flag_kind[3] = 2;
    flag_a[3]    = 32'h8000_0000;
    flag_b[3]    = 32'h1;
    flag_kind[4] = 1;
    flag_a[4]    = 32'hffff_ffff;
    flag_b[4]    = 32'h1;
    flag_kind[5] = 2;
    flag_a[5]    = 32'h0;
    flag_b[5]    = 32'h1;
    for (int k = 0; k < 3; k++) begin
      build_flags_program(2 * k);
      run_program($sformatf("flags %0d", k));
    end

    build_branch_program();
    run_program("branch and link");

    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- cpu_top.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_top (
  input  wire                     clk,
  input  wire                     nreset,
  input  wire                     run,
  output logic                    halted,
  input  wire cpu_pkg::axil_req_t host_req,
  output cpu_pkg::axil_rsp_t      host_rsp
);

  cpu_pkg::mem_req_t core_req;
  cpu_pkg::mem_req_t port_req;
  cpu_pkg::mem_req_t mem_req;
  cpu_pkg::mem_rsp_t mem_rsp;
  cpu_pkg::mem_rsp_t core_rsp;
  cpu_pkg::mem_rsp_t port_rsp;
  logic              core_gnt;
  logic              port_gnt;

  arm_core u_arm_core (
    .clk     (clk),
    .nreset  (nreset),
    .run     (run),
    .halted  (halted),
    .mem_req (core_req),
    .mem_gnt (core_gnt),
    .mem_rsp (core_rsp)
  );

  axil_host_port u_axil_host_port (
    .clk      (clk),
    .nreset   (nreset),
    .axil_in  (host_req),
    .axil_out (host_rsp),
    .mem_req  (port_req),
    .mem_gnt  (port_gnt),
    .mem_rsp  (port_rsp)
  );

  mem_arbiter u_mem_arbiter (
    .clk      (clk),
    .nreset   (nreset),
    .core_req (core_req),
    .host_req (port_req),
    .core_gnt (core_gnt),
    .host_gnt (port_gnt),
    .mem_req  (mem_req),
    .mem_rsp  (mem_rsp),
    .core_rsp (core_rsp),
    .host_rsp (port_rsp)
  );

  unified_mem u_unified_mem (
    .clk (clk),
    .req (mem_req),
    .rsp (mem_rsp)
  );

endmodule

`default_nettype wire

//--- unified_mem.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module unified_mem (
  input  wire                    clk,
  input  wire cpu_pkg::mem_req_t req,
  output cpu_pkg::mem_rsp_t      rsp
);

  logic [`XLEN-1:0] mem [0:`MEM_WORDS-1];

  // read returns old data on a write, the valid acts as completion
  always_ff @(posedge clk) begin
    if (req.valid && req.we) begin
      mem[req.addr] <= req.wdata;
    end
    rsp.rdata <= mem[req.addr];
    rsp.valid <= req.valid;
  end

endmodule

`default_nettype wire

//--- mem_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter (
  input  wire                    clk,
  input  wire                    nreset,
  input  wire cpu_pkg::mem_req_t core_req,
  input  wire cpu_pkg::mem_req_t host_req,
  output logic                   core_gnt,
  output logic                   host_gnt,
  output cpu_pkg::mem_req_t      mem_req,
  input  wire cpu_pkg::mem_rsp_t mem_rsp,
  output cpu_pkg::mem_rsp_t      core_rsp,
  output cpu_pkg::mem_rsp_t      host_rsp
);

  // which side got last cycle's grant
  logic owner_host;

  // core always wins
  assign core_gnt = core_req.valid;
  assign host_gnt = host_req.valid && !core_req.valid;
  assign mem_req  = core_req.valid ? core_req : host_req;

  always_ff @(posedge clk) begin
    if (!nreset) begin
      owner_host <= 1'b0;
    end else begin
      owner_host <= host_gnt;
    end
  end

  always_comb begin
    core_rsp       = mem_rsp;
    host_rsp       = mem_rsp;
    core_rsp.valid = mem_rsp.valid && !owner_host;
    host_rsp.valid = mem_rsp.valid && owner_host;
  end

endmodule

`default_nettype wire

//--- axil_host_port.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module axil_host_port (
  input  wire                     clk,
  input  wire                     nreset,
  input  wire cpu_pkg::axil_req_t axil_in,
  output cpu_pkg::axil_rsp_t      axil_out,
  output cpu_pkg::mem_req_t       mem_req,
  input  wire                     mem_gnt,
  input  wire cpu_pkg::mem_rsp_t  mem_rsp
);

  typedef enum logic [1:0] {hp_idle, hp_req, hp_wait, hp_resp} hp_state_e;

  hp_state_e          state;
  logic               is_wr;
  logic               err;
  logic [`MEM_AW-1:0] addr_q;
  logic [`XLEN-1:0]   wdata_q;
  logic [`XLEN-1:0]   rdata_q;
  logic               wr_hs;
  logic               rd_hs;
  logic [31:0]        addr_in;
  logic               in_range;

  // writes win when both channels are offered
  assign wr_hs    = (state == hp_idle) && axil_in.awvalid && axil_in.wvalid;
  assign rd_hs    = (state == hp_idle) && axil_in.arvalid && !(axil_in.awvalid && axil_in.wvalid);
  assign addr_in  = wr_hs ? axil_in.awaddr : axil_in.araddr;
  assign in_range = (addr_in < 32'(4 * `MEM_WORDS));

  always_comb begin
    axil_out         = '0;
    axil_out.awready = wr_hs;
    axil_out.wready  = wr_hs;
    axil_out.arready = rd_hs;
    axil_out.bvalid  = (state == hp_resp) && is_wr;
    axil_out.rvalid  = (state == hp_resp) && !is_wr;
    axil_out.bresp   = err ? cpu_pkg::resp_slverr : cpu_pkg::resp_okay;
    axil_out.rresp   = err ? cpu_pkg::resp_slverr : cpu_pkg::resp_okay;
    axil_out.rdata   = rdata_q;
  end

  always_comb begin
    mem_req.valid = (state == hp_req);
    mem_req.we    = is_wr;
    mem_req.addr  = addr_q;
    mem_req.wdata = wdata_q;
  end

  always_ff @(posedge clk) begin
    if (!nreset) begin
      state <= hp_idle;
      is_wr <= 1'b0;
      err   <= 1'b0;
    end else begin
      case (state)
        hp_idle: begin
          if (wr_hs || rd_hs) begin
            is_wr <= wr_hs;
            err   <= !in_range;
            // out of range skips the memory entirely
            state <= in_range ? hp_req : hp_resp;
          end
        end
        hp_req: begin
          if (mem_gnt) begin
            state <= hp_wait;
          end
        end
        hp_wait: begin
          if (mem_rsp.valid) begin
            state <= hp_resp;
          end
        end
        hp_resp: begin
          if (is_wr ? axil_in.bready : axil_in.rready) begin
            state <= hp_idle;
          end
        end
        default: state <= hp_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_hs || rd_hs) begin
      addr_q  <= addr_in[`MEM_AW+1:2];
      wdata_q <= axil_in.wdata;
      rdata_q <= '0;
    end else if (state == hp_wait && mem_rsp.valid && !is_wr) begin
      rdata_q <= mem_rsp.rdata;
    end
  end

endmodule

`default_nettype wire

//--- arm_core.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module arm_core (
  input  wire                    clk,
  input  wire                    nreset,
  input  wire                    run,
  output logic                   halted,
  output cpu_pkg::mem_req_t      mem_req,
  input  wire                    mem_gnt,
  input  wire cpu_pkg::mem_rsp_t mem_rsp
);

  cpu_pkg::core_state_e state;
  cpu_pkg::flags_t      cpsr;
  logic [`XLEN-1:0]     pc;
  logic [`XLEN-1:0]     ir;
  // r15 is the pc, so only r0..r14 are stored
  logic [`XLEN-1:0]     regs [0:`REG_LR];

  logic [3:0]             rn;
  logic [3:0]             rd;
  logic [3:0]             rm;
  logic [`XLEN-1:0]       pc_read;
  logic [`XLEN-1:0]       pc_next;
  logic [`XLEN-1:0]       rn_val;
  logic [`XLEN-1:0]       rd_val;
  logic [`XLEN-1:0]       rm_val;
  logic [`XLEN-1:0]       op_b;
  logic [`XLEN-1:0]       ls_addr;
  logic [`XLEN-1:0]       br_target;
  cpu_pkg::inst_class_e   iclass;
  logic                   cond_ok;
  logic                   is_load;
  logic                   do_mem;
  cpu_pkg::alu_out_t      alu_res;

  function automatic logic cond_check(input cpu_pkg::cond_e cond, input cpu_pkg::flags_t f);
    case (cond)
      cpu_pkg::cond_eq: return f.z;
      cpu_pkg::cond_ne: return !f.z;
      cpu_pkg::cond_cs: return f.c;
      cpu_pkg::cond_cc: return !f.c;
      cpu_pkg::cond_mi: return f.n;
      cpu_pkg::cond_pl: return !f.n;
      cpu_pkg::cond_vs: return f.v;
      cpu_pkg::cond_vc: return !f.v;
      cpu_pkg::cond_hi: return f.c && !f.z;
      cpu_pkg::cond_ls: return !f.c || f.z;
      cpu_pkg::cond_ge: return f.n == f.v;
      cpu_pkg::cond_lt: return f.n != f.v;
      cpu_pkg::cond_gt: return !f.z && (f.n == f.v);
      cpu_pkg::cond_le: return f.z || (f.n != f.v);
      cpu_pkg::cond_al: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // field decode of the latched instruction
  assign rn      = ir[19:16];
  assign rd      = ir[15:12];
  assign rm      = ir[3:0];
  assign iclass  = cpu_pkg::inst_class_e'(ir[27:26]);
  assign is_load = ir[20];
  assign cond_ok = cond_check(cpu_pkg::cond_e'(ir[31:28]), cpsr);
  assign do_mem  = (iclass == cpu_pkg::class_ldst) && cond_ok;

  // register reads, r15 sees the read-ahead pc
  assign pc_read = pc + `PC_AHEAD;
  assign pc_next = pc + 4;
  assign rn_val  = (rn == 4'(`REG_PC)) ? pc_read : regs[rn];
  assign rd_val  = (rd == 4'(`REG_PC)) ? pc_read : regs[rd];
  assign rm_val  = (rm == 4'(`REG_PC)) ? pc_read : regs[rm];

  assign op_b      = ir[25] ? {{(`XLEN-8){1'b0}}, ir[7:0]} : rm_val;
  assign ls_addr   = rn_val + {{(`XLEN-12){1'b0}}, ir[11:0]};
  assign br_target = pc_read + {{(`XLEN-26){ir[23]}}, ir[23:0], 2'b00};

  alu u_alu (
    .opcode   (cpu_pkg::opcode_e'(ir[24:21])),
    .op_a     (rn_val),
    .op_b     (op_b),
    .flags_in (cpsr),
    .out      (alu_res)
  );

  always_comb begin
    mem_req = '0;
    if (state == cpu_pkg::st_fetch) begin
      mem_req.valid = 1'b1;
      mem_req.addr  = pc[`MEM_AW+1:2];
    end else if (state == cpu_pkg::st_execute && do_mem) begin
      mem_req.valid = 1'b1;
      mem_req.we    = !is_load;
      mem_req.addr  = ls_addr[`MEM_AW+1:2];
      mem_req.wdata = rd_val;
    end
  end

  assign halted = (state == cpu_pkg::st_halted);

  always_ff @(posedge clk) begin
    if (!nreset) begin
      state <= cpu_pkg::st_idle;
      pc    <= '0;
      cpsr  <= '0;
      for (int i = 0; i <= `REG_LR; i++) begin
        regs[i] <= '0;
      end
    end else begin
      case (state)
        cpu_pkg::st_idle: begin
          if (run) begin
            state <= cpu_pkg::st_fetch;
          end
        end
        cpu_pkg::st_fetch: begin
          if (mem_gnt) begin
            state <= cpu_pkg::st_decode;
          end
        end
        cpu_pkg::st_decode: begin
          if (mem_rsp.valid) begin
            ir    <= mem_rsp.rdata;
            state <= cpu_pkg::st_execute;
          end
        end
        cpu_pkg::st_execute: begin
          if (do_mem) begin
            // hold the request until the arbiter takes it
            if (mem_gnt) begin
              state <= cpu_pkg::st_mem_wait;
            end
          end else begin
            pc    <= pc_next;
            state <= cpu_pkg::st_fetch;
            if (cond_ok && iclass == cpu_pkg::class_dp) begin
              if (alu_res.writes_rd && rd != 4'(`REG_PC)) begin
                regs[rd] <= alu_res.result;
              end
              if (ir[20]) begin
                cpsr <= alu_res.flags;
              end
            end else if (cond_ok && iclass == cpu_pkg::class_branch) begin
              if (ir[24]) begin
                regs[`REG_LR] <= pc_next;
              end
              pc <= br_target;
              // branch to self ends the program
              if (br_target == pc) begin
                state <= cpu_pkg::st_halted;
              end
            end
          end
        end
        cpu_pkg::st_mem_wait: begin
          if (mem_rsp.valid) begin
            if (is_load && rd != 4'(`REG_PC)) begin
              regs[rd] <= mem_rsp.rdata;
            end
            pc    <= pc_next;
            state <= cpu_pkg::st_fetch;
          end
        end
        cpu_pkg::st_halted: state <= cpu_pkg::st_halted;
        default: state <= cpu_pkg::st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- alu.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module alu (
  input  wire cpu_pkg::opcode_e opcode,
  input  wire [`XLEN-1:0]       op_a,
  input  wire [`XLEN-1:0]       op_b,
  input  wire cpu_pkg::flags_t  flags_in,
  output cpu_pkg::alu_out_t     out
);

  logic [`XLEN-1:0] add_x;
  logic [`XLEN-1:0] add_y;
  logic             cin;
  logic             arith;
  logic [`XLEN:0]   sum;
  logic [`XLEN-1:0] res;

  always_comb begin
    // adder operands, subtraction as x + ~y + carry
    add_x = op_a;
    add_y = op_b;
    cin   = 1'b0;
    arith = 1'b1;
    case (opcode)
      cpu_pkg::op_sub, cpu_pkg::op_cmp: begin
        add_y = ~op_b;
        cin   = 1'b1;
      end
      cpu_pkg::op_rsb: begin
        add_x = op_b;
        add_y = ~op_a;
        cin   = 1'b1;
      end
      cpu_pkg::op_adc: cin = flags_in.c;
      cpu_pkg::op_sbc: begin
        add_y = ~op_b;
        cin   = flags_in.c;
      end
      cpu_pkg::op_rsc: begin
        add_x = op_b;
        add_y = ~op_a;
        cin   = flags_in.c;
      end
      cpu_pkg::op_add, cpu_pkg::op_cmn: arith = 1'b1;
      default: arith = 1'b0;
    endcase

    sum = {1'b0, add_x} + {1'b0, add_y} + {{`XLEN{1'b0}}, cin};

    case (opcode)
      cpu_pkg::op_and, cpu_pkg::op_tst: res = op_a & op_b;
      cpu_pkg::op_eor, cpu_pkg::op_teq: res = op_a ^ op_b;
      cpu_pkg::op_orr: res = op_a | op_b;
      cpu_pkg::op_mov: res = op_b;
      cpu_pkg::op_bic: res = op_a & ~op_b;
      cpu_pkg::op_mvn: res = ~op_b;
      default: res = sum[`XLEN-1:0];
    endcase

    out.result  = res;
    out.flags.n = res[`XLEN-1];
    out.flags.z = (res == '0);
    // logical ops leave C and V alone
    out.flags.c = arith ? sum[`XLEN] : flags_in.c;
    out.flags.v = arith ? ((add_x[`XLEN-1] == add_y[`XLEN-1]) &&
                           (res[`XLEN-1] != add_x[`XLEN-1])) : flags_in.v;
    out.writes_rd = !(opcode inside {cpu_pkg::op_tst, cpu_pkg::op_teq,
                                     cpu_pkg::op_cmp, cpu_pkg::op_cmn});
  end

endmodule

`default_nettype wire

//--- cpu_pkg.sv
`default_nettype none

`include "cpu_defines.svh"

package cpu_pkg;

  // condition field, bits 31..28
  typedef enum logic [3:0] {
    cond_eq, cond_ne, cond_cs, cond_cc, cond_mi, cond_pl, cond_vs, cond_vc,
    cond_hi, cond_ls, cond_ge, cond_lt, cond_gt, cond_le, cond_al
  } cond_e;

  // data-processing opcode, bits 24..21
  typedef enum logic [3:0] {
    op_and, op_eor, op_sub, op_rsb, op_add, op_adc, op_sbc, op_rsc,
    op_tst, op_teq, op_cmp, op_cmn, op_orr, op_mov, op_bic, op_mvn
  } opcode_e;

  typedef enum logic [1:0] {
    class_dp     = 2'd0,
    class_ldst   = 2'd1,
    class_branch = 2'd2
  } inst_class_e;

  typedef enum logic [2:0] {
    st_idle, st_fetch, st_decode, st_execute, st_mem_wait, st_halted
  } core_state_e;

  typedef enum logic [1:0] {
    resp_okay   = 2'd0,
    resp_slverr = 2'd2
  } axil_resp_e;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

  typedef struct packed {
    logic              valid;
    logic              we;
    logic [`MEM_AW-1:0] addr;
    logic [`XLEN-1:0]   wdata;
  } mem_req_t;

  typedef struct packed {
    logic            valid;
    logic [`XLEN-1:0] rdata;
  } mem_rsp_t;

  // host to port
  typedef struct packed {
    logic             awvalid;
    logic [31:0]      awaddr;
    logic             wvalid;
    logic [`XLEN-1:0] wdata;
    logic             bready;
    logic             arvalid;
    logic [31:0]      araddr;
    logic             rready;
  } axil_req_t;

  // port to host
  typedef struct packed {
    logic             awready;
    logic             wready;
    logic             bvalid;
    axil_resp_e       bresp;
    logic             arready;
    logic             rvalid;
    logic [`XLEN-1:0] rdata;
    axil_resp_e       rresp;
  } axil_rsp_t;

  typedef struct packed {
    logic [`XLEN-1:0] result;
    flags_t           flags;
    logic             writes_rd;
  } alu_out_t;

endpackage

`default_nettype wire

//--- cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// data path and instruction width
`define XLEN 32

// unified memory geometry
`define MEM_WORDS 64
`define MEM_AW 6

// special register numbers
`define REG_LR 14
`define REG_PC 15

// r15 reads return the instruction address plus this many bytes
`define PC_AHEAD 8

`endif
